// ==== include/fcvt_params.svh ====
`ifndef FCVT_PARAMS_SVH
`define FCVT_PARAMS_SVH

// integer operand and result width
`define FCVT_XLEN 64

// exponent biases
`define FCVT_DBL_BIAS 1023
`define FCVT_SGL_BIAS 127

// fraction widths without the hidden bit
`define FCVT_DBL_MANT 52
`define FCVT_SGL_MANT 23

// unrounded exponent field, wide enough for a signed unbiased double exponent
`define FCVT_EXP_W 12

`endif

// ==== verilog/fcvt_pkg.sv ====
`include "fcvt_params.svh"

package fcvt_pkg;

    // top bit selects the family, bit 1 the 64-bit width, bit 0 unsigned
    typedef enum logic [2:0] {
        F2I_W  = 3'd0,
        F2I_WU = 3'd1,
        F2I_L  = 3'd2,
        F2I_LU = 3'd3,
        I2F_W  = 3'd4,
        I2F_WU = 3'd5,
        I2F_L  = 3'd6,
        I2F_LU = 3'd7
    } fcvt_op_e;

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } fcvt_rm_e;

    typedef enum logic {
        FMT_S = 1'b0,
        FMT_D = 1'b1
    } fcvt_fmt_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_CONVERT = 2'd1,
        ST_FINISH  = 2'd2
    } fcvt_state_e;

    typedef struct packed {
        fcvt_op_e              op;
        fcvt_rm_e              rm;
        fcvt_fmt_e             fmt;
        logic [`FCVT_XLEN-1:0] data;
    } fcvt_req_t;

    // significand keeps its leading one, right-aligned
    typedef struct packed {
        logic                     sign;
        logic [`FCVT_EXP_W-1:0]   exp;
        logic [`FCVT_DBL_MANT:0]  mant;
        logic [2:0]               grs;
        logic                     zero;
    } fcvt_unrnd_t;

    typedef struct packed {
        fcvt_op_e              op;
        logic [`FCVT_XLEN-1:0] result;
        logic [1:0]            flags;
        fcvt_unrnd_t           fp;
    } fcvt_rsp_t;

    // mag holds the significand in the input stage, the rounded integer later
    typedef struct packed {
        fcvt_op_e               op;
        fcvt_rm_e               rm;
        logic                   sign;
        logic                   nan;
        logic                   inf;
        logic                   huge;
        logic [`FCVT_EXP_W-1:0] exp;
        logic [`FCVT_XLEN:0]    mag;
        logic                   nx;
    } fcvt_f2i_stage_t;

    typedef struct packed {
        fcvt_op_e               op;
        fcvt_fmt_e              fmt;
        logic                   sign;
        logic                   zero;
        logic [`FCVT_EXP_W-1:0] exp;
        logic [`FCVT_XLEN-1:0]  mag;
    } fcvt_i2f_stage_t;

endpackage

// ==== verilog/fcvt_lzc.sv ====
`timescale 1ns/1ps

module fcvt_lzc (
    input  logic [63:0] data_i,
    output logic [5:0]  count_o
);
    logic [7:0] grp_nz;
    logic [2:0] grp_cnt [8];
    logic [2:0] grp_sel;

    // leading zeros of one byte, all-zero byte gives 7
    function automatic logic [2:0] lzc8(input logic [7:0] v);
        logic [2:0] cnt;
        cnt = 3'd7;
        for (int i = 0; i < 8; i++) begin
            if (v[i]) begin
                cnt = 3'(7 - i);
            end
        end
        return cnt;
    endfunction

    always_comb begin
        // group 0 is the top byte
        for (int g = 0; g < 8; g++) begin
            grp_nz[7 - g] = |data_i[63 - 8 * g -: 8];
            grp_cnt[g]    = lzc8(data_i[63 - 8 * g -: 8]);
        end
        // second level finds the first non-zero byte
        grp_sel = lzc8(grp_nz);
        count_o = {grp_sel, grp_cnt[grp_sel]};
    end

endmodule

// ==== verilog/fcvt_ctrl.sv ====
`timescale 1ns/1ps

module fcvt_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  fcvt_pkg::fcvt_op_e  req_op_i,
    output logic                load_in_o,
    output logic                load_mid_o,
    input  fcvt_pkg::fcvt_rsp_t f2i_rsp_i,
    input  fcvt_pkg::fcvt_rsp_t i2f_rsp_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output fcvt_pkg::fcvt_rsp_t rsp_o
);
    import fcvt_pkg::*;

    fcvt_state_e state_q;
    fcvt_state_e state_d;
    fcvt_op_e    op_q;
    logic        accept;

    // one conversion in flight, so only idle takes a request
    assign req_ready_o = (state_q == ST_IDLE);
    assign accept      = req_valid_i & req_ready_o;

    assign load_in_o   = accept;
    assign load_mid_o  = (state_q == ST_CONVERT);
    assign rsp_valid_o = (state_q == ST_FINISH);

    // mid-stage registers stay put until the next accept, so the
    // selected response holds under back-pressure
    always_comb begin
        if (op_q[2]) begin
            rsp_o = i2f_rsp_i;
        end else begin
            rsp_o = f2i_rsp_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_CONVERT;
                end
            end
            ST_CONVERT: begin
                state_d = ST_FINISH;
            end
            ST_FINISH: begin
                if (rsp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            op_q    <= F2I_W;
        end else begin
            state_q <= state_d;
            if (accept) begin
                op_q <= req_op_i;
            end
        end
    end

endmodule

// ==== verilog/fcvt_f2i.sv ====
`timescale 1ns/1ps
`include "fcvt_params.svh"

module fcvt_f2i (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_in_i,
    input  logic                load_mid_i,
    input  fcvt_pkg::fcvt_req_t req_i,
    output fcvt_pkg::fcvt_rsp_t rsp_o
);
    import fcvt_pkg::*;

    localparam int XLEN  = `FCVT_XLEN;
    localparam int H     = XLEN / 2;
    localparam int MANT  = `FCVT_DBL_MANT;
    localparam int EXPW  = `FCVT_EXP_W;
    localparam int EBITS = XLEN - 1 - MANT;
    localparam int WIDE  = 2 * XLEN;
    localparam int SHW   = $clog2(XLEN);

    logic            act_q;
    fcvt_f2i_stage_t in_d;
    fcvt_f2i_stage_t in_q;
    fcvt_f2i_stage_t mid_d;
    fcvt_f2i_stage_t mid_q;

    logic [EBITS-1:0] bexp;
    logic [MANT-1:0]  frac;
    logic [EXPW-1:0]  uexp;
    logic [EXPW-2:0]  lim;

    logic [WIDE-1:0]  base;
    logic [WIDE-1:0]  wide;
    logic [EXPW-1:0]  nexp;
    logic [SHW-1:0]   rsh;
    logic [XLEN-1:0]  ipart;
    logic             g;
    logic             r;
    logic             s;
    logic             up;

    logic [XLEN:0]    mag;
    logic             is_u;
    logic             is_64;
    logic             ovf;
    logic             nv;
    logic [XLEN-1:0]  sval;
    logic [XLEN-1:0]  max_v;
    logic [XLEN-1:0]  min_v;

    // input stage decodes the double
    always_comb begin
        bexp      = req_i.data[XLEN-2:MANT];
        frac      = req_i.data[MANT-1:0];
        uexp      = EXPW'(bexp) - EXPW'(`FCVT_DBL_BIAS);
        lim       = req_i.op[1] ? (EXPW-1)'(XLEN) : (EXPW-1)'(H);
        in_d.op   = req_i.op;
        in_d.rm   = req_i.rm;
        in_d.sign = req_i.data[XLEN-1];
        in_d.nan  = (&bexp) & (|frac);
        in_d.inf  = (&bexp) & ~(|frac);
        // 2^W and above never fits the target
        in_d.huge = ~uexp[EXPW-1] & (uexp[EXPW-2:0] >= lim);
        in_d.exp  = uexp;
        // hidden bit clear for zero and subnormals
        in_d.mag  = (XLEN+1)'({|bexp, frac});
        in_d.nx   = 1'b0;
    end

    // binary point sits between wide[XLEN] and wide[XLEN-1]
    always_comb begin
        base = WIDE'(in_q.mag[MANT:0]) << (XLEN - MANT);
        nexp = -in_q.exp;
        rsh  = (nexp > EXPW'(XLEN - 1)) ? SHW'(XLEN - 1) : nexp[SHW-1:0];
        if (in_q.exp[EXPW-1]) begin
            wide = base >> rsh;
        end else begin
            wide = base << in_q.exp[SHW-1:0];
        end
        ipart = wide[WIDE-1:XLEN];
        g     = wide[XLEN-1];
        r     = wide[XLEN-2];
        // beyond the shift cap every set bit is sticky
        if (in_q.exp[EXPW-1] && nexp > EXPW'(XLEN - 1)) begin
            s = |in_q.mag;
        end else begin
            s = |wide[XLEN-3:0];
        end
        case (in_q.rm)
            RM_RNE:  up = g & (ipart[0] | r | s);
            RM_RTZ:  up = 1'b0;
            RM_RDN:  up = in_q.sign & (g | r | s);
            RM_RUP:  up = ~in_q.sign & (g | r | s);
            RM_RMM:  up = g;
            default: up = 1'b0;
        endcase
        mid_d     = in_q;
        mid_d.mag = {1'b0, ipart} + (XLEN+1)'(up);
        mid_d.nx  = g | r | s;
    end

    // range check on the rounded magnitude before sign and saturation
    always_comb begin
        mag   = mid_q.mag;
        is_u  = mid_q.op[0];
        is_64 = mid_q.op[1];
        case (mid_q.op)
            F2I_W: begin
                ovf   = mid_q.sign ? (|mag[XLEN:H] | (mag[H-1] & |mag[H-2:0]))
                                   : |mag[XLEN:H-1];
                max_v = XLEN'({1'b0, {(H-1){1'b1}}});
                min_v = XLEN'({1'b1, {(H-1){1'b0}}});
            end
            F2I_WU: begin
                ovf   = |mag[XLEN:H];
                max_v = XLEN'({H{1'b1}});
                min_v = '0;
            end
            F2I_L: begin
                ovf   = mid_q.sign ? (mag[XLEN] | (mag[XLEN-1] & |mag[XLEN-2:0]))
                                   : |mag[XLEN:XLEN-1];
                max_v = {1'b0, {(XLEN-1){1'b1}}};
                min_v = {1'b1, {(XLEN-1){1'b0}}};
            end
            default: begin
                ovf   = mag[XLEN];
                max_v = '1;
                min_v = '0;
            end
        endcase
        // negative nonzero into an unsigned target is invalid too
        nv   = mid_q.nan | mid_q.inf | mid_q.huge | ovf | (is_u & mid_q.sign & (|mag));
        sval = mid_q.sign ? -mag[XLEN-1:0] : mag[XLEN-1:0];

        rsp_o    = '0;
        rsp_o.op = mid_q.op;
        if (nv) begin
            rsp_o.result = (mid_q.sign & ~mid_q.nan) ? min_v : max_v;
            rsp_o.flags  = 2'b10;
        end else begin
            rsp_o.result = is_64 ? sval : {{H{1'b0}}, sval[H-1:0]};
            rsp_o.flags  = {1'b0, mid_q.nx};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_q <= 1'b0;
        end else if (load_in_i) begin
            act_q <= ~req_i.op[2];
        end
    end

    always_ff @(posedge clk) begin
        if (load_in_i && !req_i.op[2]) begin
            in_q <= in_d;
        end
        if (load_mid_i && act_q) begin
            mid_q <= mid_d;
        end
    end

endmodule

// ==== verilog/fcvt_i2f.sv ====
`timescale 1ns/1ps
`include "fcvt_params.svh"

module fcvt_i2f (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_in_i,
    input  logic                load_mid_i,
    input  fcvt_pkg::fcvt_req_t req_i,
    output fcvt_pkg::fcvt_rsp_t rsp_o
);
    import fcvt_pkg::*;

    localparam int XLEN   = `FCVT_XLEN;
    localparam int H      = XLEN / 2;
    localparam int EXPW   = `FCVT_EXP_W;
    localparam int SIGW   = `FCVT_DBL_MANT + 1;
    localparam int SGL_LO = XLEN - `FCVT_SGL_MANT - 1;
    localparam int DBL_LO = XLEN - `FCVT_DBL_MANT - 1;

    logic            act_q;
    fcvt_i2f_stage_t in_d;
    fcvt_i2f_stage_t in_q;
    fcvt_i2f_stage_t mid_d;
    fcvt_i2f_stage_t mid_q;

    logic [H-1:0]    abs_w;
    logic [XLEN-1:0] abs_l;
    logic [EXPW-1:0] bias;
    logic [5:0]      lz;

    // input stage: sign and magnitude, 32-bit inputs left-aligned
    always_comb begin
        in_d.op  = req_i.op;
        in_d.fmt = req_i.fmt;
        case (req_i.op)
            I2F_W:   in_d.sign = req_i.data[H-1];
            I2F_L:   in_d.sign = req_i.data[XLEN-1];
            default: in_d.sign = 1'b0;
        endcase
        abs_w = in_d.sign ? -req_i.data[H-1:0] : req_i.data[H-1:0];
        abs_l = in_d.sign ? -req_i.data : req_i.data;
        bias  = (req_i.fmt == FMT_D) ? EXPW'(`FCVT_DBL_BIAS) : EXPW'(`FCVT_SGL_BIAS);
        // exponent assumes the top bit is set, lzc corrects it later
        if (req_i.op[1]) begin
            in_d.mag = abs_l;
            in_d.exp = bias + EXPW'(XLEN - 1);
        end else begin
            in_d.mag = {abs_w, {H{1'b0}}};
            in_d.exp = bias + EXPW'(H - 1);
        end
        in_d.zero = ~|in_d.mag;
    end

    fcvt_lzc u_lzc (
        .data_i  (in_q.mag),
        .count_o (lz)
    );

    // mid stage: normalize so the leading one lands on the top bit
    always_comb begin
        mid_d     = in_q;
        mid_d.mag = in_q.mag << lz;
        mid_d.exp = in_q.exp - EXPW'(lz);
    end

    always_comb begin
        rsp_o    = '0;
        rsp_o.op = mid_q.op;
        if (mid_q.zero) begin
            rsp_o.fp.zero = 1'b1;
        end else begin
            rsp_o.fp.sign = mid_q.sign;
            rsp_o.fp.exp  = mid_q.exp;
            if (mid_q.fmt == FMT_D) begin
                rsp_o.fp.mant = mid_q.mag[XLEN-1:DBL_LO];
                rsp_o.fp.grs  = {mid_q.mag[DBL_LO-1], mid_q.mag[DBL_LO-2],
                                 |mid_q.mag[DBL_LO-3:0]};
            end else begin
                rsp_o.fp.mant = SIGW'(mid_q.mag[XLEN-1:SGL_LO]);
                rsp_o.fp.grs  = {mid_q.mag[SGL_LO-1], mid_q.mag[SGL_LO-2],
                                 |mid_q.mag[SGL_LO-3:0]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_q <= 1'b0;
        end else if (load_in_i) begin
            act_q <= req_i.op[2];
        end
    end

    always_ff @(posedge clk) begin
        if (load_in_i && req_i.op[2]) begin
            in_q <= in_d;
        end
        if (load_mid_i && act_q) begin
            mid_q <= mid_d;
        end
    end

endmodule

// ==== verilog/fcvt_top.sv ====
`timescale 1ns/1ps

module fcvt_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  fcvt_pkg::fcvt_req_t req_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output fcvt_pkg::fcvt_rsp_t rsp_o
);
    import fcvt_pkg::*;

    logic      load_in;
    logic      load_mid;
    fcvt_rsp_t f2i_rsp;
    fcvt_rsp_t i2f_rsp;

    fcvt_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_op_i    (req_i.op),
        .load_in_o   (load_in),
        .load_mid_o  (load_mid),
        .f2i_rsp_i   (f2i_rsp),
        .i2f_rsp_i   (i2f_rsp),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    // both datapaths see every request and pick their own family
    fcvt_f2i u_f2i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_in_i  (load_in),
        .load_mid_i (load_mid),
        .req_i      (req_i),
        .rsp_o      (f2i_rsp)
    );

    fcvt_i2f u_i2f (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_in_i  (load_in),
        .load_mid_i (load_mid),
        .req_i      (req_i),
        .rsp_o      (i2f_rsp)
    );

endmodule

// ==== test/fcvt_chk.sv ====
`timescale 1ns/1ps

module fcvt_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid_i,
    input logic                req_ready_i,
    input fcvt_pkg::fcvt_req_t req_i,
    input logic                rsp_valid_i,
    input logic                rsp_ready_i,
    input fcvt_pkg::fcvt_rsp_t rsp_i
);
    int unsigned err_cnt = 0;
    logic        accept;

    assign accept = req_valid_i & req_ready_i;

    // a waiting request keeps valid and payload
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
        else begin
            $error("request dropped or changed while waiting");
            err_cnt++;
        end

    // response frozen under back-pressure
    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else begin
            $error("response dropped or changed under back-pressure");
            err_cnt++;
        end

    rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> !rsp_valid_i ##1 rsp_valid_i)
        else begin
            $error("response not valid two edges after accept");
            err_cnt++;
        end

    rsp_origin: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp_valid_i) |-> $past(accept, 2))
        else begin
            $error("response valid without an accept two edges before");
            err_cnt++;
        end

    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_ready_i && rsp_valid_i))
        else begin
            $error("request ready while a response is pending");
            err_cnt++;
        end

endmodule

bind fcvt_top fcvt_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_i       (rsp_o)
);

// ==== test/fcvt_tb.sv ====
`timescale 1ns/1ps
`include "fcvt_params.svh"

module fcvt_tb;
    import fcvt_pkg::*;

    localparam real         CLK_PERIOD = 40.0;
    localparam int          RST_CYCLES = 16;
    localparam logic [31:0] SEED       = 32'h2992_de10;
    localparam int          N_REAL     = 24;
    localparam int          N_SPECIAL  = 6;
    localparam int          N_RAND     = 24;
    localparam int          N_EDGE     = 6;
    localparam int          N_F2I      = (N_REAL + N_SPECIAL) * 4 * 5;
    localparam int          N_I2F      = (N_RAND + N_EDGE) * 4 * 2;
    localparam int          N_REQ      = N_F2I + N_I2F;
    localparam int          WD_CYCLES  = N_REQ * 12 + 100;
    localparam real         TWO_63     = 9223372036854775808.0;

    logic      clk;
    logic      rst_n;
    logic      req_valid_i;
    logic      req_ready_o;
    fcvt_req_t req_i;
    logic      rsp_valid_o;
    logic      rsp_ready_i;
    fcvt_rsp_t rsp_o;

    logic [31:0] stim_lfsr;
    logic [31:0] stall_lfsr;
    fcvt_rsp_t   exp_q [$];
    fcvt_rsp_t   exp_rsp;
    real         real_vals [N_REAL];
    logic [63:0] special_vals [N_SPECIAL];
    logic [63:0] edge_vals [N_EDGE];

    fcvt_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2.0) clk = ~clk;

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [63:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            bits  = {bits[62:0], state[0]};
        end
    endtask

    function automatic logic [63:0] real_to_u64(real r);
        if (r >= TWO_63) begin
            return 64'(longint'(r - TWO_63)) ^ 64'h8000_0000_0000_0000;
        end
        return 64'(longint'(r));
    endfunction

    function automatic fcvt_rsp_t f2i_model(fcvt_req_t req);
        fcvt_rsp_t   rsp;
        logic [63:0] bits;
        logic [63:0] max_v;
        logic [63:0] min_v;
        logic [63:0] ival;
        real         v;
        real         fl;
        real         frac;
        real         r;
        real         lo;
        real         hi;
        logic        nan;
        logic        nv;
        logic        nx;
        bits = req.data;
        case (req.op)
            F2I_W: begin
                max_v = 64'h0000_0000_7FFF_FFFF;
                min_v = 64'h0000_0000_8000_0000;
                lo    = -2147483648.0;
                hi    = 2147483648.0;
            end
            F2I_WU: begin
                max_v = 64'h0000_0000_FFFF_FFFF;
                min_v = '0;
                lo    = 0.0;
                hi    = 4294967296.0;
            end
            F2I_L: begin
                max_v = 64'h7FFF_FFFF_FFFF_FFFF;
                min_v = 64'h8000_0000_0000_0000;
                lo    = -TWO_63;
                hi    = TWO_63;
            end
            default: begin
                max_v = '1;
                min_v = '0;
                lo    = 0.0;
                hi    = 2.0 * TWO_63;
            end
        endcase
        nan  = (&bits[62:52]) & (|bits[51:0]);
        nv   = &bits[62:52];
        nx   = 1'b0;
        ival = '0;
        if (!nv) begin
            v    = $bitstoreal(bits);
            fl   = $floor(v);
            frac = v - fl;
            case (req.rm)
                RM_RNE:  r = (frac > 0.5 || (frac == 0.5 && $floor(fl / 2.0) * 2.0 != fl))
                             ? fl + 1.0 : fl;
                RM_RTZ:  r = (v < 0.0) ? $ceil(v) : fl;
                RM_RDN:  r = fl;
                RM_RUP:  r = $ceil(v);
                RM_RMM:  r = (frac > 0.5 || (frac == 0.5 && v > 0.0)) ? fl + 1.0 : fl;
                default: r = fl;
            endcase
            if (r < lo || r >= hi) begin
                nv = 1'b1;
            end else begin
                nx   = (frac != 0.0);
                ival = real_to_u64(r);
                if (!req.op[1]) begin
                    ival = {32'h0, ival[31:0]};
                end
            end
        end
        rsp       = '0;
        rsp.op    = req.op;
        rsp.flags = {nv, nx};
        if (nv) begin
            rsp.result = (bits[63] && !nan) ? min_v : max_v;
        end else begin
            rsp.result = ival;
        end
        return rsp;
    endfunction

    function automatic fcvt_rsp_t i2f_model(fcvt_req_t req);
        fcvt_rsp_t   rsp;
        logic [31:0] w;
        logic [63:0] mag;
        logic        sign;
        int          top;
        int          m;
        int          pos;
        sign = 1'b0;
        w    = req.data[31:0];
        mag  = req.data;
        case (req.op)
            I2F_W: begin
                sign = w[31];
                mag  = {32'h0, sign ? -w : w};
            end
            I2F_WU: mag = {32'h0, w};
            I2F_L: begin
                sign = mag[63];
                mag  = sign ? -mag : mag;
            end
            default: mag = req.data;
        endcase
        rsp    = '0;
        rsp.op = req.op;
        if (mag == 64'h0) begin
            rsp.fp.zero = 1'b1;
        end else begin
            top = 63;
            while (!mag[top]) begin
                top--;
            end
            m           = (req.fmt == FMT_D) ? `FCVT_DBL_MANT : `FCVT_SGL_MANT;
            rsp.fp.sign = sign;
            rsp.fp.exp  = `FCVT_EXP_W'(top + ((req.fmt == FMT_D) ? `FCVT_DBL_BIAS
                                                                 : `FCVT_SGL_BIAS));
            for (int k = 0; k <= m; k++) begin
                if (top - k >= 0) begin
                    rsp.fp.mant[m - k] = mag[top - k];
                end
            end
            // guard sits right below the kept bits
            pos = top - m - 1;
            if (pos >= 0) begin
                rsp.fp.grs[2] = mag[pos];
            end
            if (pos >= 1) begin
                rsp.fp.grs[1] = mag[pos - 1];
            end
            for (int k = 0; k <= pos - 2; k++) begin
                rsp.fp.grs[0] = rsp.fp.grs[0] | mag[k];
            end
        end
        return rsp;
    endfunction

    task automatic send_req(fcvt_op_e op, fcvt_rm_e rm, fcvt_fmt_e fmt, logic [63:0] data);
        req_valid_i <= 1'b1;
        req_i       <= '{op: op, rm: rm, fmt: fmt, data: data};
        @(posedge clk);
        while (!req_ready_o) begin
            @(posedge clk);
        end
        req_valid_i <= 1'b0;
    endtask

    // random back-pressure with ready three times in four
    always @(posedge clk) begin
        logic [63:0] bits;
        if (rst_n) begin
            draw_bits(stall_lfsr, 2, bits);
            rsp_ready_i <= (bits[1:0] != 2'b00);
        end
    end

    always @(posedge clk) begin
        if (rst_n && req_valid_i && req_ready_o) begin
            exp_q.push_back(req_i.op[2] ? i2f_model(req_i) : f2i_model(req_i));
        end
        if (rst_n && rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("response handed out at %0t with no request outstanding", $time);
                abort_run();
            end else begin
                exp_rsp = exp_q.pop_front();
                rsp_value: assert (rsp_o === exp_rsp) else begin
                    $display("ERROR at %0t: rsp_o expected %h got %h", $time, exp_rsp, rsp_o);
                    abort_run();
                end
            end
        end
    end

    always @(negedge clk) begin
        if (dut_i.u_chk.err_cnt != 0) begin
            $display("handshake assertion in fcvt_chk failed at %0t", $time);
            abort_run();
        end
    end

    initial begin
        #(CLK_PERIOD * WD_CYCLES);
        $display("timeout after %0d clock periods, responses still missing", WD_CYCLES);
        abort_run();
    end

    initial begin
        logic [63:0] bits;
        logic [63:0] pick;
        req_valid_i  = 1'b0;
        req_i        = '0;
        rsp_ready_i  = 1'b0;
        rst_n        = 1'b0;
        stim_lfsr    = SEED;
        stall_lfsr   = SEED;
        real_vals    = '{0.0, 1.0, 42.0, -7.0, 2147483647.0, -2147483648.0, 4294967295.0,
                         9007199254740992.0, 9223372036854775808.0, -9223372036854775808.0,
                         1.0e15, -1.0e15, 2.5, -2.5, 0.5, -0.5, 1.25, 3.75,
                         4294967296.0, 18446744073709551616.0, 1.0e20, -1.0e20, -0.0, 1.0e-300};
        // +inf, -inf, quiet nan, signalling nan, negative nan, smallest subnormal
        special_vals = '{64'h7FF0_0000_0000_0000, 64'hFFF0_0000_0000_0000,
                         64'h7FF8_0000_0000_0000, 64'h7FF0_0000_0000_0001,
                         64'hFFF8_0000_0000_0000, 64'h0000_0000_0000_0001};
        edge_vals    = '{64'h0000_0000_8000_0000, 64'h8000_0000_0000_0000,
                         64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_FFFF_FFFF, 64'h1, 64'h0};

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        idle_valid: assert (rsp_valid_o === 1'b0) else begin
            $display("ERROR at %0t: rsp_valid_o expected 0 got %b", $time, rsp_valid_o);
            abort_run();
        end
        idle_ready: assert (req_ready_o === 1'b1) else begin
            $display("ERROR at %0t: req_ready_o expected 1 got %b", $time, req_ready_o);
            abort_run();
        end

        // f2i with every double under every opcode and rounding mode
        for (int i = 0; i < N_REAL + N_SPECIAL; i++) begin
            bits = (i < N_REAL) ? $realtobits(real_vals[i]) : special_vals[i - N_REAL];
            for (int o = 0; o < 4; o++) begin
                for (int m = 0; m < 5; m++) begin
                    send_req(fcvt_op_e'(o), fcvt_rm_e'(m), FMT_D, bits);
                end
            end
        end

        // i2f with random magnitudes of varying width and then edge values
        for (int i = 0; i < N_RAND + N_EDGE; i++) begin
            for (int o = 4; o < 8; o++) begin
                for (int f = 0; f < 2; f++) begin
                    draw_bits(stim_lfsr, 64, bits);
                    draw_bits(stim_lfsr, 1, pick);
                    if (pick[0]) begin
                        draw_bits(stim_lfsr, 6, pick);
                        bits = bits >> pick[5:0];
                    end
                    if (i >= N_RAND) begin
                        bits = edge_vals[i - N_RAND];
                    end
                    draw_bits(stim_lfsr, 3, pick);
                    send_req(fcvt_op_e'(o), fcvt_rm_e'(3'(pick % 5)), fcvt_fmt_e'(f), bits);
                end
            end
        end

        @(posedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end

        if (dut_i.u_chk.err_cnt != 0) begin
            $display("handshake assertion in fcvt_chk failed");
            abort_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== list.f ====
+incdir+include
verilog/fcvt_pkg.sv
verilog/fcvt_lzc.sv
verilog/fcvt_ctrl.sv
verilog/fcvt_f2i.sv
verilog/fcvt_i2f.sv
verilog/fcvt_top.sv
test/fcvt_chk.sv
test/fcvt_tb.sv
